// File: src/ising_pkg.sv
package ising_pkg;

    // ======================================================================
    // Array size and precision
    // ======================================================================
    localparam int DATASPIN         = 16;                 // Spins per configuration
    localparam int ADDR_BIT         = $clog2(DATASPIN);   // Row address width
    localparam int BITJ             = 4;                  // Signed coupling weight
    localparam int BITH             = 4;                  // Signed bias
    localparam int SCALING_BIT      = 5;                  // Bias scaling, one-hot or zero
    localparam int PARTIAL_BIT      = 12;                 // One row partial energy
    localparam int ENERGY_TOTAL_BIT = 16;                 // Accumulated Hamiltonian

    // ======================================================================
    // Row storage and row request
    // ======================================================================
    // One spin row, 68 bits
    // Weight j sits at weight[j], bias on top
    typedef struct packed {
        logic signed [BITH-1:0]           hbias;   // h(i)
        logic [DATASPIN-1:0][BITJ-1:0]    weight;  // J(i,j), two's complement each
    } spin_row_t;

    // Travels with each row read, sequencer to consumer
    typedef struct packed {
        logic [ADDR_BIT-1:0]    addr;          // Row index i
        logic [DATASPIN-1:0]    spin;          // Captured spin vector
        logic                   current_spin;  // spin[i]
        logic [SCALING_BIT-1:0] hscaling;      // Captured bias scaling
    } row_req_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for start
        RUN,    // One row read per cycle
        FLUSH   // Draining memory and accumulator
    } seq_state_e;

endpackage

// File: src/weight_row_mem.sv
`timescale 1ns/1ns

module weight_row_mem (
    input  logic                              clk_i,
    input  logic                              reset_i,
    // Host write port
    input  logic                              wr_en_i,
    input  logic [ising_pkg::ADDR_BIT-1:0]    wr_addr_i,
    input  ising_pkg::spin_row_t              wr_row_i,
    // Sequencer read port
    input  logic                              rd_en_i,
    input  logic [ising_pkg::ADDR_BIT-1:0]    rd_addr_i,
    output ising_pkg::spin_row_t              rd_row_o
);

    // ======================================================================
    // Storage
    // ======================================================================
    ising_pkg::spin_row_t mem_q [ising_pkg::DATASPIN]; // One entry per spin

    // Host writes land at the clock edge
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_row_i;
        end
    end

    // ======================================================================
    // Read, one cycle latency
    // ======================================================================
    // Output register holds the last row read
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_row_o <= mem_q[rd_addr_i]; // Valid the cycle after rd_en_i
        end
    end

    // Old row would be returned here while the new one is being written,
    // the host is expected to load only while the sequencer is idle
    a_no_rw_collision : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(wr_en_i && rd_en_i && (wr_addr_i == rd_addr_i))
    ) else $error("Write and read to row %0d in the same cycle", wr_addr_i);

endmodule

// File: src/spin_row_sequencer.sv
`timescale 1ns/1ns

module spin_row_sequencer (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 start_i,
    input  logic [ising_pkg::DATASPIN-1:0]       spin_i,
    input  logic [ising_pkg::SCALING_BIT-1:0]    hscaling_i,
    output logic                                 start_acc_o,  // Start taken, clears consumer
    output logic                                 rd_en_o,
    output logic [ising_pkg::ADDR_BIT-1:0]       rd_addr_o,
    output ising_pkg::row_req_t                  req_o,        // Aligned with read data
    output logic                                 row_valid_o,
    output logic                                 last_o,
    output logic                                 busy_o
);

    ising_pkg::seq_state_e                 state_q;
    logic [ising_pkg::ADDR_BIT-1:0]        cnt_q;      // Row being read
    logic                                  flush_q;    // Second flush cycle
    logic [ising_pkg::DATASPIN-1:0]        spin_q;
    logic [ising_pkg::SCALING_BIT-1:0]     hscaling_q;
    ising_pkg::row_req_t                   req_d;      // Request for the current read
    logic                                  last_row;

    assign busy_o      = (state_q != ising_pkg::IDLE);
    assign start_acc_o = start_i && (state_q == ising_pkg::IDLE); // Starts dropped while busy
    assign rd_en_o     = (state_q == ising_pkg::RUN);
    assign last_row    = (cnt_q == ising_pkg::ADDR_BIT'(ising_pkg::DATASPIN - 1));

    // Request for the row read this cycle
    always_comb begin
        req_d.addr         = cnt_q;
        req_d.spin         = spin_q;
        req_d.current_spin = spin_q[cnt_q]; // Sign of spin i
        req_d.hscaling     = hscaling_q;
    end

    assign rd_addr_o = req_d.addr;

    // ======================================================================
    // FSM and row counter
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ising_pkg::IDLE;
            cnt_q       <= '0;
            flush_q     <= 1'b0;
            row_valid_o <= 1'b0;
            last_o      <= 1'b0;
        end else begin
            row_valid_o <= rd_en_o;              // Match memory latency
            last_o      <= rd_en_o && last_row;
            case (state_q)
                ising_pkg::IDLE: begin
                    if (start_acc_o) begin
                        state_q <= ising_pkg::RUN;
                        cnt_q   <= '0;
                    end
                end
                ising_pkg::RUN: begin
                    cnt_q <= cnt_q + 1'b1;       // Wraps to 0 after last row
                    if (last_row) begin
                        state_q <= ising_pkg::FLUSH;
                        flush_q <= 1'b0;
                    end
                end
                ising_pkg::FLUSH: begin
                    flush_q <= 1'b1;
                    if (flush_q) begin
                        state_q <= ising_pkg::IDLE; // Done cycle has passed
                    end
                end
                default: state_q <= ising_pkg::IDLE;
            endcase
        end
    end

    // Captured operands and delayed request
    always_ff @(posedge clk_i) begin
        if (start_acc_o) begin
            spin_q     <= spin_i;
            hscaling_q <= hscaling_i;
        end
        req_o <= req_d;
    end

    // Consumer decodes the scaling as a shift
    a_scaling_onehot : assert property (
        @(posedge clk_i) disable iff (reset_i)
        start_acc_o |-> $onehot0(hscaling_i)
    ) else $error("hscaling_i %0d is not zero or a power of two", hscaling_i);

endmodule

// File: src/adder_tree.sv
`timescale 1ns/1ns

module adder_tree #(
    parameter int N     = 16,  // Number of terms
    parameter int DATAW = 5    // Width of each signed term
) (
    input  logic signed [N-1:0][DATAW-1:0]          data_i,
    output logic signed [DATAW+$clog2(N)-1:0]       sum_o   // Grows by log2(N)
);

    localparam int SUMW = DATAW + $clog2(N);

    // ======================================================================
    // Recursive split
    // ======================================================================
    generate
        if (N == 1) begin : g_leaf
            // Elements of a packed array are unsigned
            assign sum_o = $signed(data_i[0]);
        end else begin : g_split
            localparam int NL    = N / 2;            // Lower half
            localparam int NR    = N - NL;           // Upper half, odd term goes here
            localparam int SUMWL = DATAW + $clog2(NL);
            localparam int SUMWR = DATAW + $clog2(NR);

            logic signed [SUMWL-1:0] sum_l;
            logic signed [SUMWR-1:0] sum_r;

            adder_tree #(
                .N     (NL),
                .DATAW (DATAW)
            ) u_left (
                .data_i (data_i[NL-1:0]),
                .sum_o  (sum_l)
            );

            adder_tree #(
                .N     (NR),
                .DATAW (DATAW)
            ) u_right (
                .data_i (data_i[N-1:NL]),
                .sum_o  (sum_r)
            );

            // Sign extend both halves before adding
            assign sum_o = SUMW'(sum_l) + SUMW'(sum_r);
        end
    endgenerate

endmodule

// File: src/partial_energy_calc.sv
`timescale 1ns/1ns

module partial_energy_calc (
    input  ising_pkg::spin_row_t                          row_i,
    input  logic [ising_pkg::DATASPIN-1:0]                spin_vec_i,
    input  logic                                          current_spin_i,
    input  logic [ising_pkg::SCALING_BIT-1:0]             hscaling_i,
    output logic signed [ising_pkg::PARTIAL_BIT-1:0]      energy_o
);

    // Extra bit so that negating the most negative weight is exact
    localparam int TERMW = ising_pkg::BITJ + 1;
    localparam int TREEW = TERMW + $clog2(ising_pkg::DATASPIN);
    localparam int HSCW  = ising_pkg::BITH + ising_pkg::SCALING_BIT - 1; // h << 4 fits

    logic [ising_pkg::DATASPIN-1:0][TERMW-1:0]   term;          // ±J(i,j)
    logic signed [TREEW-1:0]                     weight_sum;
    logic [2:0]                                  shamt;         // log2 of scaling
    logic signed [HSCW-1:0]                      hbias_ext;
    logic signed [HSCW-1:0]                      hbias_scaled;
    logic signed [ising_pkg::PARTIAL_BIT-1:0]    energy_local;  // Before current spin sign

    // ======================================================================
    // Weight times spin sign
    // ======================================================================
    always_comb begin : weight_mult
        logic signed [TERMW-1:0] w_ext;
        for (int j = 0; j < ising_pkg::DATASPIN; j++) begin
            w_ext   = {row_i.weight[j][ising_pkg::BITJ-1], row_i.weight[j]};
            term[j] = spin_vec_i[j] ? w_ext : -w_ext; // Bit 0 means -1
        end
    end

    adder_tree #(
        .N     (ising_pkg::DATASPIN),
        .DATAW (TERMW)
    ) u_adder_tree (
        .data_i (term),
        .sum_o  (weight_sum)
    );

    // ======================================================================
    // Bias scaling
    // ======================================================================
    always_comb begin
        case (hscaling_i)
            5'd2:    shamt = 3'd1;
            5'd4:    shamt = 3'd2;
            5'd8:    shamt = 3'd3;
            5'd16:   shamt = 3'd4;
            default: shamt = 3'd0;  // 0 and 1 both mean unscaled
        endcase
    end

    assign hbias_ext    = HSCW'(row_i.hbias);    // Sign extend
    assign hbias_scaled = hbias_ext <<< shamt;

    // ======================================================================
    // Row total and current spin sign
    // ======================================================================
    assign energy_local = ising_pkg::PARTIAL_BIT'(weight_sum)
                        + ising_pkg::PARTIAL_BIT'(hbias_scaled);
    assign energy_o     = current_spin_i ? energy_local : -energy_local;

endmodule

// File: src/energy_accumulator.sv
`timescale 1ns/1ns

module energy_accumulator (
    input  logic                                           clk_i,
    input  logic                                           reset_i,
    input  ising_pkg::spin_row_t                           row_i,        // From row memory
    input  ising_pkg::row_req_t                            req_i,        // Delayed request
    input  logic                                           row_valid_i,
    input  logic                                           last_i,
    input  logic                                           start_i,      // Accepted start only
    output logic signed [ising_pkg::ENERGY_TOTAL_BIT-1:0]  energy_o,
    output logic                                           done_o
);

    logic signed [ising_pkg::PARTIAL_BIT-1:0] partial; // Current row contribution

    // ======================================================================
    // Row partial energy, combinational
    // ======================================================================
    partial_energy_calc u_partial_energy_calc (
        .row_i          (row_i),
        .spin_vec_i     (req_i.spin),
        .current_spin_i (req_i.current_spin),
        .hscaling_i     (req_i.hscaling),
        .energy_o       (partial)
    );

    // ======================================================================
    // Running total
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            energy_o <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= last_i;                   // Total final one cycle after last row
            if (start_i) begin
                energy_o <= '0;
            end else if (row_valid_i) begin
                energy_o <= energy_o + ising_pkg::ENERGY_TOTAL_BIT'(partial);
            end
        end
    end

    // Final row must carry the top address
    a_last_is_top_row : assert property (
        @(posedge clk_i) disable iff (reset_i)
        last_i |-> (row_valid_i && req_i.addr == ising_pkg::ADDR_BIT'(ising_pkg::DATASPIN - 1))
    ) else $error("last_i on row %0d", req_i.addr);

    // A run of rows only begins two cycles after an accepted start
    a_no_row_after_last : assert property (
        @(posedge clk_i) disable iff (reset_i)
        $rose(row_valid_i) |-> $past(start_i, 2)
    ) else $error("row_valid_i rose without a new start");

endmodule

// File: src/ising_energy_top.sv
`timescale 1ns/1ns

module ising_energy_top (
    input  logic                                           clk_i,
    input  logic                                           reset_i,
    // Host row loading
    input  logic                                           wr_en_i,
    input  logic [ising_pkg::ADDR_BIT-1:0]                 wr_addr_i,
    input  ising_pkg::spin_row_t                           wr_row_i,
    // Run control
    input  logic                                           start_i,
    input  logic [ising_pkg::DATASPIN-1:0]                 spin_i,
    input  logic [ising_pkg::SCALING_BIT-1:0]              hscaling_i,
    output logic signed [ising_pkg::ENERGY_TOTAL_BIT-1:0]  energy_o,
    output logic                                           done_o,
    output logic                                           busy_o
);

    // ======================================================================
    // Internal wiring
    // ======================================================================
    logic                              start_acc;   // Single point of start acceptance
    logic                              rd_en;
    logic [ising_pkg::ADDR_BIT-1:0]    rd_addr;
    ising_pkg::row_req_t               req;
    logic                              row_valid;
    logic                              last;
    ising_pkg::spin_row_t              rd_row;

    // Producer
    spin_row_sequencer u_spin_row_sequencer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .spin_i      (spin_i),
        .hscaling_i  (hscaling_i),
        .start_acc_o (start_acc),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .req_o       (req),
        .row_valid_o (row_valid),
        .last_o      (last),
        .busy_o      (busy_o)
    );

    // Buffer
    weight_row_mem u_weight_row_mem (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_row_i  (wr_row_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_row_o  (rd_row)
    );

    // Consumer
    energy_accumulator u_energy_accumulator (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .row_i       (rd_row),
        .req_i       (req),
        .row_valid_i (row_valid),
        .last_i      (last),
        .start_i     (start_acc),
        .energy_o    (energy_o),
        .done_o      (done_o)
    );

    // Rows change only between runs
    a_write_when_idle : assert property (
        @(posedge clk_i) disable iff (reset_i)
        wr_en_i |-> !busy_o
    ) else $error("Row write to %0d while busy", wr_addr_i);

endmodule

// File: verif/tb_ising_energy.sv
`timescale 1ns/1ns

module tb_ising_energy;

    localparam int N_SPIN       = ising_pkg::DATASPIN;
    localparam int LAT          = N_SPIN + 2;              // Start to done
    localparam int NUM_RUNS     = 20;
    localparam int RUN_CYCLES   = N_SPIN + 4;
    localparam int LOAD_WRITES  = 4 * N_SPIN + 2 * 4;      // Four full loads, two partial
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + LOAD_WRITES + RESET_CYCLES + 200;

    // DUT inputs
    logic                                          clk_i;
    logic                                          reset_i;
    logic                                          wr_en_i;
    logic [ising_pkg::ADDR_BIT-1:0]                wr_addr_i;
    ising_pkg::spin_row_t                          wr_row_i;
    logic                                          start_i;
    logic [N_SPIN-1:0]                             spin_i;
    logic [ising_pkg::SCALING_BIT-1:0]             hscaling_i;
    // DUT outputs
    logic signed [ising_pkg::ENERGY_TOTAL_BIT-1:0] energy_o;
    logic                                          done_o;
    logic                                          busy_o;

    // Reference model of the row memory
    int w_model [N_SPIN][N_SPIN];
    int h_model [N_SPIN];
    int exp_energy = 0;                                    // Model result of the accepted start

    // Checker state, one entry per past cycle
    logic              start_taken;
    logic [LAT-1:0]    acc_hist = '0;                      // Bit k set, start taken k+1 edges ago
    logic              reset_q  = 1'b0;
    logic signed [ising_pkg::ENERGY_TOTAL_BIT-1:0] energy_q = '0;
    int                cycle_cnt = 0;

    ising_energy_top ising_energy_top_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en_i),
        .wr_addr_i  (wr_addr_i),
        .wr_row_i   (wr_row_i),
        .start_i    (start_i),
        .spin_i     (spin_i),
        .hscaling_i (hscaling_i),
        .energy_o   (energy_o),
        .done_o     (done_o),
        .busy_o     (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;                        // 20 ns period
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic tick();
        @(posedge clk_i);
        #2;                                                // Drive after the edge
    endtask

    function automatic int rand_weight();
        return int'($urandom_range(15)) - 8;               // Full 4-bit signed range
    endfunction

    function automatic logic [ising_pkg::SCALING_BIT-1:0] random_scaling();
        case ($urandom_range(5))
            0:       return 5'd0;
            1:       return 5'd1;
            2:       return 5'd2;
            3:       return 5'd4;
            4:       return 5'd8;
            default: return 5'd16;
        endcase
    endfunction

    // Hamiltonian straight from the spin rule, bit 1 is +1
    function automatic int model_energy(input logic [N_SPIN-1:0] spin,
                                        input logic [ising_pkg::SCALING_BIT-1:0] scaling);
        int scale;
        int total;
        int field;
        scale = (scaling == 5'd0) ? 1 : int'(scaling);     // Zero acts as 1
        total = 0;
        for (int i = 0; i < N_SPIN; i++) begin
            field = 0;
            for (int j = 0; j < N_SPIN; j++) begin
                field += w_model[i][j] * (spin[j] ? 1 : -1);
            end
            field += h_model[i] * scale;
            total += (spin[i] ? 1 : -1) * field;
        end
        return total;
    endfunction

    // Write one model row into the DUT
    task automatic send_row(input int addr);
        ising_pkg::spin_row_t row;
        for (int j = 0; j < N_SPIN; j++) begin
            row.weight[j] = ising_pkg::BITJ'(w_model[addr][j]);
        end
        row.hbias = ising_pkg::BITH'(h_model[addr]);
        wr_addr_i = ising_pkg::ADDR_BIT'(addr);
        wr_row_i  = row;
        wr_en_i   = 1'b1;
        tick();
        wr_en_i   = 1'b0;
    endtask

    task automatic load_random_rows();
        for (int i = 0; i < N_SPIN; i++) begin
            for (int j = 0; j < N_SPIN; j++) begin
                w_model[i][j] = rand_weight();
            end
            h_model[i] = rand_weight();
            send_row(i);
        end
    endtask

    task automatic load_constant_rows(input int w, input int h);
        for (int i = 0; i < N_SPIN; i++) begin
            for (int j = 0; j < N_SPIN; j++) begin
                w_model[i][j] = w;
            end
            h_model[i] = h;
            send_row(i);
        end
    endtask

    task automatic rewrite_random_rows(input int count);
        int addr;
        for (int k = 0; k < count; k++) begin
            addr = int'($urandom_range(N_SPIN - 1));
            for (int j = 0; j < N_SPIN; j++) begin
                w_model[addr][j] = rand_weight();
            end
            h_model[addr] = rand_weight();
            send_row(addr);
        end
    endtask

    // One energy run, optionally poking start while busy
    task automatic run_energy(input logic [N_SPIN-1:0] spin,
                              input logic [ising_pkg::SCALING_BIT-1:0] scaling,
                              input bit poke_busy);
        exp_energy = model_energy(spin, scaling);
        spin_i     = spin;
        hscaling_i = scaling;
        start_i    = 1'b1;
        tick();
        start_i    = 1'b0;
        if (poke_busy) begin
            repeat (5) tick();
            spin_i     = ~spin;                            // Must not reach the result
            hscaling_i = 5'd4;
            start_i    = 1'b1;
            tick();
            start_i    = 1'b0;
        end
        while (!done_o) begin
            tick();                                        // Bounded by the cycle counter
        end
        tick();                                            // Let busy_o drop
    endtask

    // ======================================================================
    // Checker state and timeout
    // ======================================================================
    // Start counts only outside the window of a previous accepted start
    assign start_taken = start_i && !(|acc_hist) && !reset_i;

    always @(posedge clk_i) begin
        reset_q  <= reset_i;
        energy_q <= energy_o;
        if (reset_i) begin
            acc_hist <= '0;
        end else begin
            acc_hist <= {acc_hist[LAT-2:0], start_taken};
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    a_reset_busy : assert property (@(posedge clk_i) reset_q |-> !busy_o)
    else begin
        $display("CHECK FAILED at %0t: busy_o expected 0 actual %0b", $time, $sampled(busy_o));
        stop_on_error();
    end

    a_reset_done : assert property (@(posedge clk_i) reset_q |-> !done_o)
    else begin
        $display("CHECK FAILED at %0t: done_o expected 0 actual %0b", $time, $sampled(done_o));
        stop_on_error();
    end

    a_reset_energy : assert property (@(posedge clk_i) reset_q |-> (energy_o == '0))
    else begin
        $display("CHECK FAILED at %0t: energy_o expected 0 actual %0d",
                 $time, $sampled(energy_o));
        stop_on_error();
    end

    // High from one to LAT edges after an accepted start
    a_busy_window : assert property (
        @(posedge clk_i) disable iff (reset_i)
        busy_o == (|acc_hist)
    ) else begin
        $display("CHECK FAILED at %0t: busy_o expected %0b actual %0b",
                 $time, $sampled(|acc_hist), $sampled(busy_o));
        stop_on_error();
    end

    // Exactly one pulse, LAT edges after an accepted start
    a_done_timing : assert property (
        @(posedge clk_i) disable iff (reset_i)
        done_o == acc_hist[LAT-1]
    ) else begin
        $display("CHECK FAILED at %0t: done_o expected %0b actual %0b",
                 $time, $sampled(acc_hist[LAT-1]), $sampled(done_o));
        stop_on_error();
    end

    a_energy_at_done : assert property (
        @(posedge clk_i) disable iff (reset_i)
        done_o |-> (int'(energy_o) == exp_energy)
    ) else begin
        $display("CHECK FAILED at %0t: energy_o expected %0d actual %0d",
                 $time, exp_energy, $sampled(energy_o));
        stop_on_error();
    end

    // Idle cycles keep the total, starting right after the done cycle
    a_energy_held : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (!busy_o && !reset_q) |-> (energy_o == energy_q)
    ) else begin
        $display("CHECK FAILED at %0t: energy_o expected %0d actual %0d",
                 $time, $sampled(energy_q), $sampled(energy_o));
        stop_on_error();
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        reset_i    = 1'b1;
        wr_en_i    = 1'b0;
        wr_addr_i  = '0;
        wr_row_i   = '0;
        start_i    = 1'b0;
        spin_i     = '0;
        hscaling_i = '0;
        void'($urandom(32'h8ab56e16));
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        tick();

        load_random_rows();
        run_energy(N_SPIN'($urandom()), 5'd0, 1'b0);      // Scaling sweep
        run_energy('1, 5'd1, 1'b0);                        // All spins up
        run_energy('0, 5'd2, 1'b0);                        // All spins down
        run_energy(N_SPIN'($urandom()), 5'd4, 1'b0);
        run_energy(N_SPIN'($urandom()), 5'd8, 1'b0);
        run_energy(N_SPIN'($urandom()), 5'd16, 1'b0);
        run_energy(N_SPIN'($urandom()), 5'd2, 1'b1);      // Start while busy

        rewrite_random_rows(4);                            // Updated rows between runs
        run_energy(N_SPIN'($urandom()), random_scaling(), 1'b0);
        rewrite_random_rows(4);
        run_energy(N_SPIN'($urandom()), random_scaling(), 1'b0);

        load_constant_rows(-8, -8);                        // Most negative weights
        run_energy('1, 5'd16, 1'b0);
        run_energy('0, 5'd16, 1'b0);
        load_constant_rows(7, 7);                          // Most positive weights
        run_energy('1, 5'd16, 1'b0);
        run_energy(N_SPIN'($urandom()), 5'd16, 1'b0);

        load_random_rows();
        repeat (7) begin
            run_energy(N_SPIN'($urandom()), random_scaling(), 1'b0);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: compile.f
src/ising_pkg.sv
src/weight_row_mem.sv
src/spin_row_sequencer.sv
src/adder_tree.sv
src/partial_energy_calc.sv
src/energy_accumulator.sv
src/ising_energy_top.sv
verif/tb_ising_energy.sv

// File: Makefile
# Verilator simulation of the Ising energy testbench

VERILATOR ?= verilator
TOP       ?= tb_ising_energy
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: simulate clean

# Build, run, then fail unless the pass line is in the output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
